//--- src/snooper_consts.svh
`ifndef SNOOPER_CONSTS_SVH
`define SNOOPER_CONSTS_SVH

// Source PC width; the trace port carries it as two 32-bit words
`define SNP_PC_W 64

// Configuration write data width, one half of a PC bound per write
`define SNP_DATA_W 32

// Number of independent PC address ranges
`define SNP_NUM_RANGES 4

// Entries in the accepted-record FIFO
`define SNP_FIFO_DEPTH 8

// Width of the saturating rejected and overflow counters
`define SNP_CNT_W 16

// Configuration register address width
`define SNP_ADDR_W 5

// Control register address
`define SNP_ADDR_CTRL 5'd0

// First range register; range r uses 1 + 4r up to 4 + 4r
// Order within a range is base low, base high, last low, last high
`define SNP_ADDR_RANGE_BASE 5'd1

`endif

//--- src/snooper_pkg.sv
`include "snooper_consts.svh"

package snooper_pkg;

   // Privilege level as reported by the core, encoding 2 is reserved
   typedef enum logic [1:0] {
      PRIV_LVL_U = 2'd0,
      PRIV_LVL_S = 2'd1,
      PRIV_LVL_M = 2'd3
   } priv_lvl_t;

   // Control-transfer type codes, 6 and 7 are reserved
   typedef enum logic [3:0] {
      CTR_TYPE_NONE    = 4'd0,
      CTR_TYPE_EXC     = 4'd1,
      CTR_TYPE_INTR    = 4'd2,
      CTR_TYPE_TRET    = 4'd3,
      CTR_TYPE_NTBR    = 4'd4,
      CTR_TYPE_TKBR    = 4'd5,
      CTR_TYPE_INDCALL = 4'd8,
      CTR_TYPE_DIRCALL = 4'd9,
      CTR_TYPE_INDJMP  = 4'd10,
      CTR_TYPE_DIRJMP  = 4'd11,
      CTR_TYPE_CORSWAP = 4'd12,
      CTR_TYPE_RET     = 4'd13,
      CTR_TYPE_INDLJMP = 4'd14,
      CTR_TYPE_DIRLJMP = 4'd15
   } ctr_type_t;

   // One trace record; metadata[3:0] holds the transfer type
   typedef struct packed {
      logic [31:0] pc_src_h;
      logic [31:0] pc_src_l;
      priv_lvl_t   priv_lvl;
      logic [7:0]  metadata;
   } trace_t;

   // Control register image, declared MSB first so excinh lands on bit 0
   typedef struct packed {
      logic [`SNP_NUM_RANGES-1:0] pc_range_en;
      logic                       trace_mode;
      logic                       u_mode;
      logic                       s_mode;
      logic                       m_mode;
      logic                       ntbren;
      logic                       dirljmpinh;
      logic                       indljmpinh;
      logic                       retinh;
      logic                       corswapinh;
      logic                       dirjmpinh;
      logic                       indjmpinh;
      logic                       dircallinh;
      logic                       indcallinh;
      logic                       tkbrinh;
      logic                       tretinh;
      logic                       intrinh;
      logic                       excinh;
   } ctr_ctrl_t;

   // Inclusive PC window
   typedef struct packed {
      logic [`SNP_PC_W-1:0] base;
      logic [`SNP_PC_W-1:0] last;
   } pc_range_t;

   typedef struct packed {
      ctr_ctrl_t                            ctrl;
      pc_range_t [`SNP_NUM_RANGES-1:0]      ranges;
   } filter_cfg_t;

   // Counter increment that sticks at all ones
   function automatic logic [`SNP_CNT_W-1:0] sat_inc(input logic [`SNP_CNT_W-1:0] cnt);
      return (&cnt) ? cnt : cnt + 1'b1;
   endfunction

endpackage

//--- src/snooper_cfg_regs.sv
`include "snooper_consts.svh"

module snooper_cfg_regs
   import snooper_pkg::*;
(
   input  logic                   clk_i,
   input  logic                   rst_n_i,
   input  logic                   cfg_we_i,
   input  logic [`SNP_ADDR_W-1:0] cfg_addr_i,
   input  logic [`SNP_DATA_W-1:0] cfg_wdata_i,
   output filter_cfg_t            cfg_o
);

   localparam int unsigned n_range_regs = 4 * `SNP_NUM_RANGES;
   localparam int unsigned idx_w        = $clog2(`SNP_NUM_RANGES);
   localparam int unsigned ctrl_w       = $bits(ctr_ctrl_t);

   filter_cfg_t            cfg_q;
   logic [`SNP_ADDR_W-1:0] range_off;
   logic                   ctrl_sel;
   logic                   range_sel;
   logic [idx_w-1:0]       range_idx;
   logic [1:0]             range_fld;

   // Address decode into control word or one half of a range bound
   assign ctrl_sel  = (cfg_addr_i == `SNP_ADDR_CTRL);
   assign range_off = cfg_addr_i - `SNP_ADDR_RANGE_BASE;
   assign range_sel = (cfg_addr_i >= `SNP_ADDR_RANGE_BASE) && (range_off < n_range_regs);
   assign range_fld = range_off[1:0];
   assign range_idx = range_off[idx_w+1:2];

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         cfg_q <= '0;
      end else if (cfg_we_i) begin
         if (ctrl_sel) begin
            // Only the defined control bits are kept
            cfg_q.ctrl <= ctr_ctrl_t'(cfg_wdata_i[ctrl_w-1:0]);
         end else if (range_sel) begin
            unique case (range_fld)
               2'd0: begin
                  cfg_q.ranges[range_idx].base[`SNP_DATA_W-1:0] <= cfg_wdata_i;
               end
               2'd1: begin
                  cfg_q.ranges[range_idx].base[`SNP_PC_W-1:`SNP_DATA_W] <= cfg_wdata_i;
               end
               2'd2: begin
                  cfg_q.ranges[range_idx].last[`SNP_DATA_W-1:0] <= cfg_wdata_i;
               end
               default: begin
                  cfg_q.ranges[range_idx].last[`SNP_PC_W-1:`SNP_DATA_W] <= cfg_wdata_i;
               end
            endcase
         end
         // Anything else falls outside the map and is dropped
      end
   end

   assign cfg_o = cfg_q;

endmodule

//--- src/ctr_type_filter.sv
module ctr_type_filter
   import snooper_pkg::*;
(
   input  trace_t    trace_i,
   input  ctr_ctrl_t ctrl_i,
   output logic      priv_ok_o,
   output logic      type_ok_o
);

   ctr_type_t ctr_type;
   logic      type_en;

   assign ctr_type = ctr_type_t'(trace_i.metadata[3:0]);

   always_comb begin
      type_en = 1'b0;
      case (ctr_type)
         CTR_TYPE_EXC:     type_en = ~ctrl_i.excinh;
         CTR_TYPE_INTR:    type_en = ~ctrl_i.intrinh;
         CTR_TYPE_TRET:    type_en = ~ctrl_i.tretinh;
         // Not-taken branches are opt-in rather than opt-out
         CTR_TYPE_NTBR:    type_en = ctrl_i.ntbren;
         CTR_TYPE_TKBR:    type_en = ~ctrl_i.tkbrinh;
         CTR_TYPE_INDCALL: type_en = ~ctrl_i.indcallinh;
         CTR_TYPE_DIRCALL: type_en = ~ctrl_i.dircallinh;
         CTR_TYPE_INDJMP:  type_en = ~ctrl_i.indjmpinh;
         CTR_TYPE_DIRJMP:  type_en = ~ctrl_i.dirjmpinh;
         CTR_TYPE_CORSWAP: type_en = ~ctrl_i.corswapinh;
         CTR_TYPE_RET:     type_en = ~ctrl_i.retinh;
         CTR_TYPE_INDLJMP: type_en = ~ctrl_i.indljmpinh;
         CTR_TYPE_DIRLJMP: type_en = ~ctrl_i.dirljmpinh;
         // NONE and the reserved codes
         default:          type_en = 1'b0;
      endcase
   end

   // Instruction-trace mode lets every type through
   assign type_ok_o = type_en | ctrl_i.trace_mode;

   // Level 2 has no enable, so it can never match
   assign priv_ok_o = (ctrl_i.m_mode & (trace_i.priv_lvl == PRIV_LVL_M)) |
                      (ctrl_i.s_mode & (trace_i.priv_lvl == PRIV_LVL_S)) |
                      (ctrl_i.u_mode & (trace_i.priv_lvl == PRIV_LVL_U));

endmodule

//--- src/pc_range_matcher.sv
`include "snooper_consts.svh"

module pc_range_matcher
   import snooper_pkg::*;
(
   input  trace_t                           trace_i,
   input  pc_range_t [`SNP_NUM_RANGES-1:0]  ranges_i,
   input  logic [`SNP_NUM_RANGES-1:0]       range_en_i,
   output logic                             in_range_o
);

   logic [`SNP_PC_W-1:0]       pc;
   logic [`SNP_NUM_RANGES-1:0] hit;

   assign pc = {trace_i.pc_src_h, trace_i.pc_src_l};

   // Both bounds are part of the window
   for (genvar r = 0; r < `SNP_NUM_RANGES; r++) begin : g_range
      assign hit[r] = range_en_i[r] &
                      (ranges_i[r].base <= pc) &
                      (pc <= ranges_i[r].last);
   end

   assign in_range_o = |hit;

endmodule

//--- src/trace_filter.sv
`include "snooper_consts.svh"

module trace_filter
   import snooper_pkg::*;
(
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  trace_t                trace_i,
   input  logic                  pc_valid_i,
   input  filter_cfg_t           cfg_i,
   output logic                  push_o,
   output trace_t                rec_o,
   output logic [`SNP_CNT_W-1:0] rejected_count_o
);

   logic                  priv_ok;
   logic                  type_ok;
   logic                  in_range;
   logic                  accept;
   logic                  push_q;
   trace_t                rec_q;
   logic [`SNP_CNT_W-1:0] rej_cnt_q;

   ctr_type_filter u_type_filter (
      .trace_i   (trace_i),
      .ctrl_i    (cfg_i.ctrl),
      .priv_ok_o (priv_ok),
      .type_ok_o (type_ok)
   );

   pc_range_matcher u_range_matcher (
      .trace_i    (trace_i),
      .ranges_i   (cfg_i.ranges),
      .range_en_i (cfg_i.ctrl.pc_range_en),
      .in_range_o (in_range)
   );

   assign accept = pc_valid_i & priv_ok & type_ok & in_range;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         push_q    <= 1'b0;
         rej_cnt_q <= '0;
      end else begin
         push_q <= accept;
         if (pc_valid_i && !accept) begin
            rej_cnt_q <= sat_inc(rej_cnt_q);
         end
      end
   end

   // Record payload only moves when something is accepted
   always_ff @(posedge clk_i) begin
      if (accept) begin
         rec_q <= trace_i;
      end
   end

   assign push_o           = push_q;
   assign rec_o            = rec_q;
   assign rejected_count_o = rej_cnt_q;

endmodule

//--- src/trace_fifo.sv
`include "snooper_consts.svh"

module trace_fifo
   import snooper_pkg::*;
(
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  logic                  push_i,
   input  trace_t                rec_i,
   input  logic                  rd_pop_i,
   output logic                  rd_valid_o,
   output trace_t                rd_data_o,
   output logic [`SNP_CNT_W-1:0] overflow_count_o
);

   localparam int unsigned depth = `SNP_FIFO_DEPTH;
   localparam int unsigned ptr_w = $clog2(depth);
   localparam int unsigned cnt_w = $clog2(depth + 1);

   trace_t                mem_q [depth];
   logic [ptr_w-1:0]      wr_ptr_q;
   logic [ptr_w-1:0]      rd_ptr_q;
   logic [cnt_w-1:0]      count_q;
   logic [`SNP_CNT_W-1:0] ovf_cnt_q;
   logic                  empty;
   logic                  full;
   logic                  do_pop;
   logic                  do_push;

   assign empty  = (count_q == '0);
   assign full   = (count_q == cnt_w'(depth));
   assign do_pop = rd_pop_i & ~empty;
   // A pop in the same cycle frees the slot the push needs
   assign do_push = push_i & (~full | do_pop);

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         wr_ptr_q  <= '0;
         rd_ptr_q  <= '0;
         count_q   <= '0;
         ovf_cnt_q <= '0;
      end else begin
         if (do_push) begin
            wr_ptr_q <= (wr_ptr_q == ptr_w'(depth - 1)) ? '0 : wr_ptr_q + 1'b1;
         end
         if (do_pop) begin
            rd_ptr_q <= (rd_ptr_q == ptr_w'(depth - 1)) ? '0 : rd_ptr_q + 1'b1;
         end
         unique case ({do_push, do_pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
         if (push_i && !do_push) begin
            ovf_cnt_q <= sat_inc(ovf_cnt_q);
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (do_push) begin
         mem_q[wr_ptr_q] <= rec_i;
      end
   end

   assign rd_valid_o       = ~empty;
   assign rd_data_o        = mem_q[rd_ptr_q];
   assign overflow_count_o = ovf_cnt_q;

endmodule

//--- src/trace_snooper_top.sv
`include "snooper_consts.svh"

module trace_snooper_top
   import snooper_pkg::*;
(
   input  logic                   clk_i,
   input  logic                   rst_n_i,
   input  logic                   cfg_we_i,
   input  logic [`SNP_ADDR_W-1:0] cfg_addr_i,
   input  logic [`SNP_DATA_W-1:0] cfg_wdata_i,
   input  trace_t                 trace_i,
   input  logic                   pc_valid_i,
   input  logic                   rd_pop_i,
   output logic                   rd_valid_o,
   output trace_t                 rd_data_o,
   output logic [`SNP_CNT_W-1:0]  rejected_count_o,
   output logic [`SNP_CNT_W-1:0]  overflow_count_o
);

   filter_cfg_t cfg;
   logic        push;
   trace_t      rec;

   snooper_cfg_regs u_cfg_regs (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .cfg_we_i    (cfg_we_i),
      .cfg_addr_i  (cfg_addr_i),
      .cfg_wdata_i (cfg_wdata_i),
      .cfg_o       (cfg)
   );

   // Filter output is registered, so the FIFO sees one record per cycle at most
   trace_filter u_filter (
      .clk_i            (clk_i),
      .rst_n_i          (rst_n_i),
      .trace_i          (trace_i),
      .pc_valid_i       (pc_valid_i),
      .cfg_i            (cfg),
      .push_o           (push),
      .rec_o            (rec),
      .rejected_count_o (rejected_count_o)
   );

   trace_fifo u_fifo (
      .clk_i            (clk_i),
      .rst_n_i          (rst_n_i),
      .push_i           (push),
      .rec_i            (rec),
      .rd_pop_i         (rd_pop_i),
      .rd_valid_o       (rd_valid_o),
      .rd_data_o        (rd_data_o),
      .overflow_count_o (overflow_count_o)
   );

endmodule

//--- dv/tb_trace_snooper.sv
`include "snooper_consts.svh"

module tb_trace_snooper
   import snooper_pkg::*;
();

   localparam logic [31:0] CTRL_NTBREN = 32'h1 << 12;
   localparam logic [31:0] CTRL_M      = 32'h1 << 13;
   localparam logic [31:0] CTRL_S      = 32'h1 << 14;
   localparam logic [31:0] CTRL_TRACE  = 32'h1 << 16;
   localparam logic [31:0] CTRL_EN0    = 32'h1 << 17;

   logic                   clk_i;
   logic                   rst_n_i;
   logic                   cfg_we_i;
   logic [`SNP_ADDR_W-1:0] cfg_addr_i;
   logic [`SNP_DATA_W-1:0] cfg_wdata_i;
   trace_t                 trace_i;
   logic                   pc_valid_i;
   logic                   rd_pop_i;
   logic                   rd_valid_o;
   trace_t                 rd_data_o;
   logic [`SNP_CNT_W-1:0]  rejected_count_o;
   logic [`SNP_CNT_W-1:0]  overflow_count_o;

   // Mirror of the configuration and the expected FIFO contents
   logic [20:0]            m_ctrl;
   logic [63:0]            m_base [`SNP_NUM_RANGES];
   logic [63:0]            m_last [`SNP_NUM_RANGES];
   trace_t                 exp_q [$];
   trace_t                 pend_rec;
   logic                   pend_v;
   logic                   chk_en;
   logic [`SNP_CNT_W-1:0]  exp_rej;
   logic [`SNP_CNT_W-1:0]  exp_ovf;
   logic [31:0]            rng;
   int                     err_cnt;
   int                     start_err;
   int                     fail_tests;

   trace_snooper_top dut0 (.*);

   initial begin
      clk_i = 1'b0;
      forever #4 clk_i = ~clk_i;
   end

   function automatic logic [31:0] next_rand();
      rng = rng ^ (rng << 13);
      rng = rng ^ (rng >> 17);
      rng = rng ^ (rng << 5);
      return rng;
   endfunction

   function automatic trace_t make_rec(input logic [31:0] h, input logic [31:0] l,
                                       input logic [1:0] lvl, input logic [7:0] meta);
      trace_t r;
      r.pc_src_h = h;
      r.pc_src_l = l;
      r.priv_lvl = priv_lvl_t'(lvl);
      r.metadata = meta;
      return r;
   endfunction

   // Expected filter decision for a valid record under the mirrored configuration
   function automatic logic ref_accept(input trace_t t);
      logic [1:0]  lvl;
      logic [3:0]  code;
      logic [63:0] pc;
      logic        priv_ok;
      logic        type_en;
      logic        in_range;
      lvl  = t.priv_lvl;
      code = t.metadata[3:0];
      pc   = {t.pc_src_h, t.pc_src_l};
      priv_ok = (lvl == 2'd3 && m_ctrl[13]) || (lvl == 2'd1 && m_ctrl[14]) ||
                (lvl == 2'd0 && m_ctrl[15]);
      // Inhibit bits follow the type codes with NTBR and the reserved codes left out
      case (code)
         4'd1, 4'd2, 4'd3: type_en = !m_ctrl[code - 4'd1];
         4'd4:             type_en = m_ctrl[12];
         4'd5:             type_en = !m_ctrl[3];
         4'd8, 4'd9, 4'd10, 4'd11, 4'd12, 4'd13, 4'd14, 4'd15: begin
            type_en = !m_ctrl[code - 4'd4];
         end
         default:          type_en = 1'b0;
      endcase
      in_range = 1'b0;
      for (int r = 0; r < `SNP_NUM_RANGES; r++) begin
         if (m_ctrl[17 + r] && m_base[r] <= pc && pc <= m_last[r]) begin
            in_range = 1'b1;
         end
      end
      return priv_ok && (type_en || m_ctrl[16]) && in_range;
   endfunction

   task automatic apply_cfg(input logic [4:0] a, input logic [31:0] d);
      int off;
      off = int'(a) - 1;
      if (a == 5'd0) begin
         m_ctrl = d[20:0];
      end else if (off < 4 * `SNP_NUM_RANGES) begin
         case (off % 4)
            0:       m_base[off / 4][31:0]  = d;
            1:       m_base[off / 4][63:32] = d;
            2:       m_last[off / 4][31:0]  = d;
            default: m_last[off / 4][63:32] = d;
         endcase
      end
   endtask

   // Model of the filter stage and FIFO that steps on the edge where the DUT samples
   always @(posedge clk_i) begin
      chk_en = rst_n_i;
      if (!rst_n_i) begin
         exp_q.delete();
         pend_v  = 1'b0;
         exp_rej = '0;
         exp_ovf = '0;
         m_ctrl  = '0;
         for (int r = 0; r < `SNP_NUM_RANGES; r++) begin
            m_base[r] = '0;
            m_last[r] = '0;
         end
      end else begin
         if (rd_pop_i && exp_q.size() != 0) begin
            void'(exp_q.pop_front());
         end
         if (pend_v) begin
            if (exp_q.size() < `SNP_FIFO_DEPTH) begin
               exp_q.push_back(pend_rec);
            end else if (exp_ovf != '1) begin
               exp_ovf = exp_ovf + 1'b1;
            end
         end
         pend_v = 1'b0;
         if (pc_valid_i) begin
            if (ref_accept(trace_i)) begin
               pend_v   = 1'b1;
               pend_rec = trace_i;
            end else if (exp_rej != '1) begin
               exp_rej = exp_rej + 1'b1;
            end
         end
         if (cfg_we_i) begin
            apply_cfg(cfg_addr_i, cfg_wdata_i);
         end
      end
   end

   task automatic check_val(input string name, input logic [127:0] got,
                            input logic [127:0] exp);
      if (got !== exp) begin
         $display("[ERROR] t=%0t %s got %h expected %h", $time, name, got, exp);
         err_cnt++;
      end
   endtask

   // Outputs only move on the rising edge and have settled by the falling edge
   always @(negedge clk_i) begin
      if (chk_en) begin
         check_val("rd_valid_o", rd_valid_o, exp_q.size() != 0);
         if (rd_valid_o && exp_q.size() != 0) begin
            check_val("rd_data_o", rd_data_o, exp_q[0]);
         end
         check_val("rejected_count_o", rejected_count_o, exp_rej);
         check_val("overflow_count_o", overflow_count_o, exp_ovf);
      end
   end

   task automatic idle(input int n);
      repeat (n) @(negedge clk_i);
   endtask

   task automatic write_cfg(input logic [4:0] a, input logic [31:0] d);
      cfg_we_i    = 1'b1;
      cfg_addr_i  = a;
      cfg_wdata_i = d;
      @(negedge clk_i);
      cfg_we_i = 1'b0;
   endtask

   task automatic set_range(input int r, input logic [63:0] base, input logic [63:0] last);
      write_cfg(`SNP_ADDR_RANGE_BASE + 5'(4 * r), base[31:0]);
      write_cfg(`SNP_ADDR_RANGE_BASE + 5'(4 * r + 1), base[63:32]);
      write_cfg(`SNP_ADDR_RANGE_BASE + 5'(4 * r + 2), last[31:0]);
      write_cfg(`SNP_ADDR_RANGE_BASE + 5'(4 * r + 3), last[63:32]);
   endtask

   task automatic send(input trace_t t);
      trace_i    = t;
      pc_valid_i = 1'b1;
      @(negedge clk_i);
      pc_valid_i = 1'b0;
   endtask

   task automatic send_all_types();
      for (int c = 0; c < 16; c++) begin
         send(make_rec(32'h0, 32'h40 + 4 * c, 2'd3, {4'ha, 4'(c)}));
      end
   endtask

   task automatic drain();
      int n;
      idle(2);
      rd_pop_i = 1'b1;
      n = 0;
      while (rd_valid_o && n < 40) begin
         @(negedge clk_i);
         n++;
      end
      if (rd_valid_o) begin
         $display("Timeout: FIFO still holds records after %0d pop cycles", n);
         err_cnt++;
      end
      rd_pop_i = 1'b0;
   endtask

   task automatic end_test(input int num, input string name);
      if (err_cnt > start_err) begin
         fail_tests++;
         $display("Test %0d %s: FAILED with %0d errors", num, name, err_cnt - start_err);
      end else begin
         $display("Test %0d %s: ok", num, name);
      end
      start_err = err_cnt;
   endtask

   initial begin
      logic [63:0] base;
      logic [63:0] last;
      logic [3:0]  en_mask;
      logic [31:0] t;
      logic [4:0]  a;
      logic [15:0] ovf_start;
      rng = 32'h7423;
      rst_n_i = 1'b0;
      cfg_we_i = 1'b0;
      cfg_addr_i = '0;
      cfg_wdata_i = '0;
      trace_i = '0;
      pc_valid_i = 1'b0;
      rd_pop_i = 1'b0;
      err_cnt = 0;
      start_err = 0;
      fail_tests = 0;
      repeat (8) @(negedge clk_i);
      rst_n_i = 1'b1;
      @(negedge clk_i);

      check_val("rd_valid_o", rd_valid_o, 1'b0);
      check_val("rejected_count_o", rejected_count_o, 0);
      check_val("overflow_count_o", overflow_count_o, 0);
      send(make_rec(32'h0, 32'h100, 2'd3, 8'h01));
      check_val("rejected_count_o", rejected_count_o, 1);
      end_test(1, "reset state");

      rd_pop_i = 1'b1;
      set_range(0, 64'h0, '1);
      for (int i = -1; i < 12; i++) begin
         write_cfg(`SNP_ADDR_CTRL, CTRL_M | CTRL_EN0 | ((i >= 0) ? (32'h1 << i) : 32'h0));
         send_all_types();
      end
      write_cfg(`SNP_ADDR_CTRL, CTRL_M | CTRL_EN0 | CTRL_NTBREN);
      send_all_types();
      write_cfg(`SNP_ADDR_CTRL, CTRL_M | CTRL_EN0 | CTRL_TRACE | 32'hfff);
      send_all_types();
      drain();
      end_test(2, "transfer types");

      rd_pop_i = 1'b1;
      for (int m = 0; m < 8; m++) begin
         write_cfg(`SNP_ADDR_CTRL, CTRL_EN0 | (32'(m) << 13));
         for (int lvl = 0; lvl < 4; lvl++) begin
            send(make_rec(32'h0, 32'h200 + lvl, 2'(lvl), 8'h01));
         end
      end
      drain();
      end_test(3, "privilege levels");

      rd_pop_i = 1'b1;
      for (int r = 0; r < `SNP_NUM_RANGES; r++) begin
         // Range 0 starts at a zero low word and range 3 ends at an all-ones one
         base = {32'h10 + 32'(r), 32'(r) * 32'h100};
         last = (r == 3) ? {base[63:32], 32'hffff_ffff} : base + 64'h40;
         set_range(r, base, last);
         for (int en = 0; en < 2; en++) begin
            en_mask = en ? (4'b1 << r) : ~(4'b1 << r);
            write_cfg(`SNP_ADDR_CTRL, CTRL_M | (32'(en_mask) << 17));
            send(make_rec(base[63:32] - 32'(base[31:0] == 0), base[31:0] - 1, 2'd3, 8'h05));
            send(make_rec(base[63:32], base[31:0], 2'd3, 8'h05));
            send(make_rec(last[63:32], last[31:0], 2'd3, 8'h05));
            send(make_rec(last[63:32] + 32'(&last[31:0]), last[31:0] + 1, 2'd3, 8'h05));
            send(make_rec(base[63:32] + 1, base[31:0], 2'd3, 8'h05));
            send(make_rec(base[63:32] - 1, last[31:0], 2'd3, 8'h05));
         end
      end
      drain();
      end_test(4, "PC ranges");

      rd_pop_i = 1'b0;
      set_range(0, 64'h0, '1);
      write_cfg(`SNP_ADDR_CTRL, CTRL_M | CTRL_EN0);
      ovf_start = overflow_count_o;
      for (int i = 0; i < 12; i++) begin
         send(make_rec(32'h5, 32'h1000 + i, 2'd3, 8'h05));
      end
      idle(2);
      check_val("overflow_count_o", overflow_count_o - ovf_start, 4);
      drain();
      end_test(5, "FIFO overflow");

      write_cfg(`SNP_ADDR_CTRL, CTRL_M | CTRL_S | 32'hf << 17);
      for (int cyc = 0; cyc < 2000; cyc++) begin
         t = next_rand();
         a = t[4] ? 5'd0 : t[9:5];
         cfg_we_i = (t[3:0] == 4'd0);
         cfg_addr_i = a;
         // High words of the bounds stay small so that PCs land inside often
         cfg_wdata_i = (a != 0 && !a[0]) ? {31'b0, t[10]} : next_rand();
         t = next_rand();
         trace_i = make_rec({31'b0, t[0]}, next_rand(), t[2:1], t[10:3]);
         pc_valid_i = t[11] | t[12];
         rd_pop_i = t[13];
         @(negedge clk_i);
      end
      cfg_we_i = 1'b0;
      pc_valid_i = 1'b0;
      drain();
      end_test(6, "random traffic");

      $display("Tests run: 6, failed: %0d, errors: %0d", fail_tests, err_cnt);
      if (err_cnt == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

//--- all.f
+incdir+src
src/snooper_pkg.sv
src/snooper_cfg_regs.sv
src/ctr_type_filter.sv
src/pc_range_matcher.sv
src/trace_filter.sv
src/trace_fifo.sv
src/trace_snooper_top.sv
dv/tb_trace_snooper.sv
